// File: mem_rs.f
hw/mem_rs_pkg.sv
hw/ld_slot_if.sv
hw/st_view_if.sv
hw/ld_slot.sv
hw/store_queue.sv
hw/ld_dispatch.sv
hw/issue_select.sv
hw/mem_rs.sv
dv/mem_rs_chk.sv
dv/mem_rs_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mem_rs testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mem_rs_tb -f mem_rs.f -o Vmem_rs_tb
./obj_dir/Vmem_rs_tb +verilator+error+limit+100 | tee sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi

// File: dv/mem_rs_tb.sv
`timescale 1ns/1ps

module mem_rs_tb;

    localparam int LD_DEPTH = 4;
    localparam int ST_DEPTH = 4;

    // one waiting op as the model sees it
    // seq orders stores against loads
    typedef struct packed {
        logic [15:0] seq;
        logic [2:0]  funct3;
        logic [3:0]  rob;
        logic [5:0]  pd;
        logic [5:0]  ps1;
        logic        ps1_rdy;
        logic [31:0] ps1_v;
        logic [5:0]  ps2;
        logic        ps2_rdy;
        logic [31:0] ps2_v;
        logic [31:0] imm;
    } ent_t;

    logic        clk, rst, flush, disp_valid, funit_ready;
    logic [6:0]  disp_opcode;
    logic [2:0]  disp_funct3;
    logic [3:0]  disp_rob_idx, rob_head_idx, issue_rob_idx, issue_rmask;
    logic [5:0]  disp_pd, disp_ps1, disp_ps2, cdb_tag, issue_pd;
    logic        disp_ps1_ready, disp_ps2_ready, cdb_valid;
    logic [31:0] disp_ps1_v, disp_ps2_v, disp_imm, cdb_value;
    logic        ld_full, st_full, issue_valid, issue_is_store;
    logic [31:0] issue_addr, issue_wdata;

    ent_t        st_q [$];
    ent_t        ld_q [$];
    int          st_pushed = 0;
    int          issue_cnt = 0;
    int          sent = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] lfsr;
    logic [2:0]  f3s [5];

    mem_rs #(.LD_DEPTH(LD_DEPTH), .ST_DEPTH(ST_DEPTH)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] imm12();
        logic [31:0] r;
        r = rnd(12);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // {rmask, addr} from the load type and the low address bits
    function automatic logic [35:0] expected_access(input logic [2:0] f3,
                                                    input logic [31:0] base,
                                                    input logic [31:0] imm);
        logic [31:0] addr;
        logic [3:0]  mask;
        int          lanes;
        int          off;
        addr = base + imm;
        off = int'(addr[1:0]);
        case (f3)
            mem_rs_pkg::F3_LB, mem_rs_pkg::F3_LBU: lanes = 1;
            mem_rs_pkg::F3_LH, mem_rs_pkg::F3_LHU: lanes = 2;
            mem_rs_pkg::F3_LW:                     lanes = 4;
            default:                               lanes = 0;
        endcase
        mask = '0;
        for (int i = 0; i < 4; i++) begin
            if (lanes == 4 || (i >= off && i < off + lanes)) begin
                mask[i] = 1'b1;
            end
        end
        return {mask, addr};
    endfunction

    function automatic ent_t wake_ent(input ent_t e);
        ent_t r;
        r = e;
        if (cdb_valid && !e.ps1_rdy && e.ps1 == cdb_tag) begin
            r.ps1_rdy = 1'b1;
            r.ps1_v   = cdb_value;
        end
        if (cdb_valid && !e.ps2_rdy && e.ps2 == cdb_tag) begin
            r.ps2_rdy = 1'b1;
            r.ps2_v   = cdb_value;
        end
        return r;
    endfunction

    // an older store blocks a load until its word is known and different
    function automatic logic load_eligible(input ent_t l);
        logic [31:0] la;
        logic [31:0] sa;
        logic        ok;
        la = l.ps1_v + l.imm;
        ok = l.ps1_rdy;
        foreach (st_q[j]) begin
            sa = st_q[j].ps1_v + st_q[j].imm;
            if (st_q[j].seq < l.seq && (!st_q[j].ps1_rdy || sa[31:2] == la[31:2])) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // predict this cycle, compare, then advance the model past the edge
    task automatic model_step();
        int          ld_n;
        int          st_n;
        int          win;
        logic        exp_valid;
        logic        exp_store;
        logic [35:0] acc;
        ent_t        e;
        ld_n = ld_q.size();
        st_n = st_q.size();
        win = -1;
        exp_store = funit_ready && st_n > 0 && st_q[0].ps1_rdy && st_q[0].ps2_rdy
                    && st_q[0].rob == rob_head_idx;
        for (int i = 0; i < ld_n; i++) begin
            if (funit_ready && !exp_store && win < 0 && load_eligible(ld_q[i])) begin
                win = i;
            end
        end
        exp_valid = exp_store || win >= 0;
        check("ld_full", 32'(ld_full), 32'(ld_n == LD_DEPTH));
        check("st_full", 32'(st_full), 32'(st_n == ST_DEPTH));
        check("issue_valid", 32'(issue_valid), 32'(exp_valid));
        if (issue_valid) begin
            issue_cnt++;
        end
        if (exp_valid && issue_valid) begin
            e = exp_store ? st_q[0] : ld_q[win];
            acc = expected_access(e.funct3, e.ps1_v, e.imm);
            check("issue_is_store", 32'(issue_is_store), 32'(exp_store));
            check("issue_rob_idx", 32'(issue_rob_idx), 32'(e.rob));
            check("issue_pd", 32'(issue_pd), 32'(e.pd));
            check("issue_addr", issue_addr, acc[31:0]);
            check("issue_rmask", 32'(issue_rmask), exp_store ? 32'd0 : 32'(acc[35:32]));
            if (exp_store) begin
                check("issue_wdata", issue_wdata, e.ps2_v);
            end
        end
        if (exp_store) begin
            void'(st_q.pop_front());
        end else if (win >= 0) begin
            ld_q.delete(win);
        end
        if (flush) begin
            st_q.delete();
            ld_q.delete();
        end else begin
            foreach (st_q[j]) st_q[j] = wake_ent(st_q[j]);
            foreach (ld_q[j]) ld_q[j] = wake_ent(ld_q[j]);
            e = '{seq: 16'(st_pushed), funct3: disp_funct3, rob: disp_rob_idx, pd: disp_pd,
                  ps1: disp_ps1, ps1_rdy: disp_ps1_ready, ps1_v: disp_ps1_v,
                  ps2: disp_ps2, ps2_rdy: disp_ps2_ready, ps2_v: disp_ps2_v, imm: disp_imm};
            if (disp_valid && disp_opcode == mem_rs_pkg::OP_LOAD && ld_n < LD_DEPTH) begin
                e.ps2_rdy = 1'b1;
                ld_q.push_back(wake_ent(e));
            end else if (disp_valid && disp_opcode == mem_rs_pkg::OP_STORE
                         && st_n < ST_DEPTH) begin
                st_q.push_back(wake_ent(e));
                st_pushed++;
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (rst) begin
                st_q.delete();
                ld_q.delete();
            end else begin
                model_step();
            end
        end
    end

    task automatic send(input logic is_store, input logic [2:0] f3, input logic [3:0] rob,
                        input logic [5:0] ps1, input logic ps1_rdy, input logic [31:0] base,
                        input logic [5:0] ps2, input logic ps2_rdy, input logic [31:0] imm);
        int t;
        t = 0;
        while ((is_store ? st_full : ld_full) && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (t == 100) begin
            timeouts++;
            $display("timeout at %0t ns: full flag never dropped", $time);
        end
        disp_valid     = 1'b1;
        disp_opcode    = is_store ? mem_rs_pkg::OP_STORE : mem_rs_pkg::OP_LOAD;
        disp_funct3    = f3;
        disp_rob_idx   = rob;
        disp_pd        = 6'(rnd(6));
        disp_ps1       = ps1;
        disp_ps1_ready = ps1_rdy;
        disp_ps1_v     = base;
        disp_ps2       = ps2;
        disp_ps2_ready = ps2_rdy;
        disp_ps2_v     = rnd(32);
        disp_imm       = imm;
        @(negedge clk);
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
        sent++;
    endtask

    task automatic broadcast(input logic [5:0] tag, input logic [31:0] value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic wait_issues(input int target);
        int t;
        t = 0;
        while (issue_cnt < target && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (issue_cnt < target) begin
            timeouts++;
            $display("timeout at %0t ns: only %0d of %0d ops issued", $time, issue_cnt, target);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int          order [4];
        lfsr = 32'he07e5e95;
        f3s = '{mem_rs_pkg::F3_LB, mem_rs_pkg::F3_LH, mem_rs_pkg::F3_LW,
                mem_rs_pkg::F3_LBU, mem_rs_pkg::F3_LHU};
        order = '{3, 1, 0, 2};
        rst = 1'b1;
        {disp_valid, flush, disp_opcode, disp_funct3, disp_rob_idx, disp_pd} = '0;
        {disp_ps1, disp_ps1_ready, disp_ps1_v, disp_ps2, disp_ps2_ready, disp_ps2_v} = '0;
        {disp_imm, cdb_valid, cdb_tag, cdb_value, rob_head_idx} = '0;
        funit_ready = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // ready loads of every width, then a random mix
        foreach (f3s[k]) send(0, f3s[k], 4'(k), 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        for (int k = 0; k < 12; k++) begin
            send(0, f3s[rnd(3) % 5], 4'(rnd(4)), 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        end
        wait_issues(sent);

        // base operand from a later broadcast and from one in the dispatch cycle
        send(0, mem_rs_pkg::F3_LW, 4'd1, 6'd12, 0, rnd(32), 6'd0, 1, imm12());
        repeat (5) @(negedge clk);
        broadcast(6'd12, rnd(32));
        wait_issues(sent);
        cdb_valid = 1'b1;
        cdb_tag   = 6'd13;
        cdb_value = rnd(32);
        send(0, mem_rs_pkg::F3_LH, 4'd2, 6'd13, 0, rnd(32), 6'd0, 1, imm12());
        wait_issues(sent);

        // stores leave in order and only at the ROB head
        send(1, 3'b010, 4'd1, 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        send(1, 3'b000, 4'd2, 6'd0, 1, rnd(32), 6'd14, 0, imm12());
        send(1, 3'b001, 4'd3, 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        repeat (3) @(negedge clk);
        broadcast(6'd14, rnd(32));
        // the second store matches the ROB head but is not the oldest
        rob_head_idx = 4'd2;
        repeat (3) @(negedge clk);
        for (int r = 1; r <= 3; r++) begin
            rob_head_idx = 4'(r);
            wait_issues(sent - 3 + r);
        end

        // loads against older stores with unknown, distant and same-word addresses
        a = rnd(32) & 32'hffff_fff0;
        send(1, 3'b010, 4'd8, 6'd20, 0, 32'd0, 6'd0, 1, 32'd0);
        send(0, mem_rs_pkg::F3_LW, 4'd4, 6'd0, 1, a, 6'd0, 1, 32'd0);
        repeat (4) @(negedge clk);
        broadcast(6'd20, a + 32'd64);
        wait_issues(sent - 1);
        b = rnd(32) & 32'hffff_fff0;
        send(1, 3'b010, 4'd9, 6'd0, 1, b, 6'd0, 1, 32'd0);
        send(0, mem_rs_pkg::F3_LBU, 4'd5, 6'd0, 1, b, 6'd0, 1, 32'd2);
        repeat (4) @(negedge clk);
        rob_head_idx = 4'd8;
        wait_issues(sent - 2);
        rob_head_idx = 4'd9;
        wait_issues(sent);

        // slot 0 frees early, so the oldest waiting load lands in slot 1
        send(0, mem_rs_pkg::F3_LW, 4'd7, 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        for (int k = 0; k < LD_DEPTH; k++) begin
            send(0, mem_rs_pkg::F3_LW, 4'(k), 6'(40 + k), 0, 32'd0, 6'd0, 1, imm12());
        end
        // wake out of order while stalled, oldest goes first
        funit_ready = 1'b0;
        foreach (order[k]) broadcast(6'(40 + order[k]), rnd(32));
        repeat (2) @(negedge clk);
        funit_ready = 1'b1;
        wait_issues(sent);

        // fill the store queue and the load slots, then flush them away
        rob_head_idx = 4'd0;
        for (int k = 0; k < ST_DEPTH; k++) begin
            send(1, 3'b010, 4'(10 + k), 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        end
        for (int k = 0; k < LD_DEPTH; k++) begin
            send(0, mem_rs_pkg::F3_LW, 4'(k), 6'd50, 0, rnd(32), 6'd0, 1, imm12());
        end
        repeat (2) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        sent = issue_cnt;
        rob_head_idx = 4'd10;
        repeat (6) @(negedge clk);
        send(0, mem_rs_pkg::F3_LB, 4'd6, 6'd0, 1, rnd(32), 6'd0, 1, imm12());
        wait_issues(sent);
        repeat (2) @(negedge clk);

        errors += int'(UUT.u_chk.fail_cnt);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dv/mem_rs_chk.sv
`timescale 1ns/1ps

module mem_rs_chk (
    input logic       clk,
    input logic       rst,
    input logic       flush,
    input logic       funit_ready,
    input logic       issue_valid,
    input logic       issue_is_store,
    input logic [3:0] issue_rmask
);

    int unsigned fail_cnt = 0;

    // the functional unit takes every issue
    a_issue_needs_unit: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> funit_ready)
        else begin
            fail_cnt++;
            $error("issue_valid high while funit_ready low");
        end

    // stores read no byte lanes
    a_store_no_rmask: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_is_store) |-> issue_rmask == 4'b0000)
        else begin
            fail_cnt++;
            $error("store issued with nonzero issue_rmask");
        end

    a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> !issue_valid)
        else begin
            fail_cnt++;
            $error("issue_valid high in the cycle after flush");
        end

endmodule

bind mem_rs mem_rs_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .funit_ready   (funit_ready),
    .issue_valid   (issue_valid),
    .issue_is_store(issue_is_store),
    .issue_rmask   (issue_rmask)
);

// File: hw/mem_rs.sv
`timescale 1ns/1ps

module mem_rs #(
    parameter int LD_DEPTH = 4,
    parameter int ST_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    disp_valid,
    input  mem_rs_pkg::opcode_t     disp_opcode,
    input  mem_rs_pkg::funct3_t     disp_funct3,
    input  mem_rs_pkg::rob_idx_t    disp_rob_idx,
    input  mem_rs_pkg::preg_t       disp_pd,
    input  mem_rs_pkg::preg_t       disp_ps1,
    input  logic                    disp_ps1_ready,
    input  mem_rs_pkg::word_t       disp_ps1_v,
    input  mem_rs_pkg::preg_t       disp_ps2,
    input  logic                    disp_ps2_ready,
    input  mem_rs_pkg::word_t       disp_ps2_v,
    input  mem_rs_pkg::word_t       disp_imm,
    input  mem_rs_pkg::rob_idx_t    rob_head_idx,
    input  logic                    cdb_valid,
    input  mem_rs_pkg::preg_t       cdb_tag,
    input  mem_rs_pkg::word_t       cdb_value,
    input  logic                    funit_ready,
    output logic                    ld_full,
    output logic                    st_full,
    output logic                    issue_valid,
    output logic                    issue_is_store,
    output mem_rs_pkg::rob_idx_t    issue_rob_idx,
    output mem_rs_pkg::preg_t       issue_pd,
    output mem_rs_pkg::word_t       issue_addr,
    output mem_rs_pkg::byte_mask_t  issue_rmask,
    output mem_rs_pkg::word_t       issue_wdata
);

    mem_rs_pkg::mem_op_t            disp_op;
    mem_rs_pkg::cdb_t               cdb;
    logic                           st_push;
    logic                           st_issue;
    logic [$clog2(ST_DEPTH)-1:0]    st_issue_idx;
    logic                           ld_issue;
    logic [$clog2(LD_DEPTH)-1:0]    ld_issue_age;

    assign disp_op = '{funct3: disp_funct3, rob_idx: disp_rob_idx, pd: disp_pd,
                       ps1: disp_ps1, ps1_ready: disp_ps1_ready, ps1_v: disp_ps1_v,
                       ps2: disp_ps2, ps2_ready: disp_ps2_ready, ps2_v: disp_ps2_v,
                       imm: disp_imm};
    assign cdb     = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

    ld_slot_if #(.ST_DEPTH(ST_DEPTH), .LD_DEPTH(LD_DEPTH)) slot_if [LD_DEPTH] ();
    st_view_if #(.ST_DEPTH(ST_DEPTH)) st_if ();

    assign st_full = st_if.full;

    ld_dispatch #(.LD_DEPTH(LD_DEPTH), .ST_DEPTH(ST_DEPTH)) u_dispatch (
        .disp_valid (disp_valid),
        .disp_opcode(disp_opcode),
        .disp_op    (disp_op),
        .st_push    (st_push),
        .st_view    (st_if),
        .slots      (slot_if),
        .ld_full    (ld_full)
    );

    for (genvar gi = 0; gi < LD_DEPTH; gi++) begin : g_ld
        ld_slot #(.LD_DEPTH(LD_DEPTH), .ST_DEPTH(ST_DEPTH)) u_slot (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .cdb         (cdb),
            .st_issue    (st_issue),
            .st_issue_idx(st_issue_idx),
            .ld_issue    (ld_issue),
            .ld_issue_age(ld_issue_age),
            .slot        (slot_if[gi])
        );
    end

    store_queue #(.LD_DEPTH(LD_DEPTH), .ST_DEPTH(ST_DEPTH)) u_stq (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .cdb         (cdb),
        .rob_head_idx(rob_head_idx),
        .push        (st_push),
        .push_op     (disp_op),
        .view        (st_if)
    );

    issue_select #(.LD_DEPTH(LD_DEPTH), .ST_DEPTH(ST_DEPTH)) u_select (
        .funit_ready   (funit_ready),
        .slots         (slot_if),
        .st_view       (st_if),
        .issue_valid   (issue_valid),
        .issue_is_store(issue_is_store),
        .issue_rob_idx (issue_rob_idx),
        .issue_pd      (issue_pd),
        .issue_addr    (issue_addr),
        .issue_rmask   (issue_rmask),
        .issue_wdata   (issue_wdata),
        .st_issue      (st_issue),
        .st_issue_idx  (st_issue_idx),
        .ld_issue      (ld_issue),
        .ld_issue_age  (ld_issue_age)
    );

endmodule

// File: hw/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
    parameter int LD_DEPTH = 4,
    parameter int ST_DEPTH = 4
) (
    input  logic                          funit_ready,
    ld_slot_if.selector                   slots [LD_DEPTH],
    st_view_if.selector                   st_view,
    output logic                          issue_valid,
    output logic                          issue_is_store,
    output mem_rs_pkg::rob_idx_t          issue_rob_idx,
    output mem_rs_pkg::preg_t             issue_pd,
    output mem_rs_pkg::word_t             issue_addr,
    output mem_rs_pkg::byte_mask_t        issue_rmask,
    output mem_rs_pkg::word_t             issue_wdata,
    output logic                          st_issue,
    output logic [$clog2(ST_DEPTH)-1:0]   st_issue_idx,
    output logic                          ld_issue,
    output logic [$clog2(LD_DEPTH)-1:0]   ld_issue_age
);

    localparam int AGE_W = $clog2(LD_DEPTH);

    logic                    s_ready [LD_DEPTH];
    logic [AGE_W-1:0]        s_age   [LD_DEPTH];
    mem_rs_pkg::mem_op_t     s_op    [LD_DEPTH];
    mem_rs_pkg::word_t       s_addr  [LD_DEPTH];
    mem_rs_pkg::byte_mask_t  s_rmask [LD_DEPTH];
    logic [ST_DEPTH-1:0]     s_deps  [LD_DEPTH];
    logic [LD_DEPTH-1:0]     elig;
    logic [LD_DEPTH-1:0]     grant;
    logic                    ld_found;
    logic [AGE_W-1:0]        ld_sel;
    logic [AGE_W-1:0]        best_age;
    logic                    st_win;
    logic                    ld_win;

    for (genvar gi = 0; gi < LD_DEPTH; gi++) begin : g_slot
        assign s_ready[gi]     = slots[gi].ready && slots[gi].busy;
        assign s_age[gi]       = slots[gi].age;
        assign s_op[gi]        = slots[gi].op;
        assign s_addr[gi]      = slots[gi].addr;
        assign s_rmask[gi]     = slots[gi].rmask;
        assign s_deps[gi]      = slots[gi].deps;
        assign slots[gi].grant = grant[gi];
    end

    // a load may pass an older store only when the store sits in another word
    always_comb begin
        ld_found = 1'b0;
        ld_sel   = '0;
        best_age = '0;
        for (int i = 0; i < LD_DEPTH; i++) begin
            elig[i] = s_ready[i];
            for (int j = 0; j < ST_DEPTH; j++) begin
                if (s_deps[i][j] && (!st_view.addr_known[j] ||
                        st_view.addr[j][31:2] == s_addr[i][31:2])) begin
                    elig[i] = 1'b0;
                end
            end
            if (elig[i] && (!ld_found || s_age[i] < best_age)) begin
                ld_found = 1'b1;
                ld_sel   = AGE_W'(i);
                best_age = s_age[i];
            end
        end
    end

    assign st_win = funit_ready && st_view.head_ready;
    assign ld_win = funit_ready && !st_win && ld_found;

    for (genvar gi = 0; gi < LD_DEPTH; gi++) begin : g_grant
        assign grant[gi] = ld_win && ld_sel == AGE_W'(gi);
    end

    assign st_view.pop   = st_win;
    assign st_issue      = st_win;
    assign st_issue_idx  = st_view.head_idx;
    assign ld_issue      = ld_win;
    assign ld_issue_age  = best_age;
    assign issue_valid   = st_win || ld_win;

    always_comb begin
        issue_is_store = st_win;
        issue_rob_idx  = '0;
        issue_pd       = '0;
        issue_addr     = '0;
        issue_rmask    = '0;
        issue_wdata    = '0;
        if (st_win) begin
            issue_rob_idx = st_view.head_op.rob_idx;
            issue_pd      = st_view.head_op.pd;
            issue_addr    = st_view.addr[st_view.head_idx];
            issue_wdata   = st_view.head_op.ps2_v;
        end else if (ld_win) begin
            issue_rob_idx = s_op[ld_sel].rob_idx;
            issue_pd      = s_op[ld_sel].pd;
            issue_addr    = s_addr[ld_sel];
            issue_rmask   = s_rmask[ld_sel];
        end
    end

endmodule

// File: hw/ld_dispatch.sv
`timescale 1ns/1ps

module ld_dispatch #(
    parameter int LD_DEPTH = 4,
    parameter int ST_DEPTH = 4
) (
    input  logic                   disp_valid,
    input  mem_rs_pkg::opcode_t    disp_opcode,
    input  mem_rs_pkg::mem_op_t    disp_op,
    output logic                   st_push,
    st_view_if.reader              st_view,
    ld_slot_if.dispatcher          slots [LD_DEPTH],
    output logic                   ld_full
);

    localparam int AGE_W = $clog2(LD_DEPTH);

    logic [LD_DEPTH-1:0]  busy_v;
    logic [LD_DEPTH-1:0]  alloc_v;
    logic [AGE_W-1:0]     free_idx;
    logic [AGE_W:0]       busy_cnt;
    logic                 is_load;
    mem_rs_pkg::mem_op_t  load_op;

    assign is_load = disp_opcode == mem_rs_pkg::OP_LOAD;
    assign st_push = disp_valid && disp_opcode == mem_rs_pkg::OP_STORE && !st_view.full;

    // loads never read rs2
    always_comb begin
        load_op           = disp_op;
        load_op.ps2_ready = 1'b1;
    end

    always_comb begin
        free_idx = '0;
        busy_cnt = '0;
        for (int i = LD_DEPTH - 1; i >= 0; i--) begin
            if (!busy_v[i]) begin
                free_idx = AGE_W'(i);
            end
            busy_cnt = busy_cnt + (AGE_W + 1)'(busy_v[i]);
        end
    end

    assign ld_full = &busy_v;

    for (genvar gi = 0; gi < LD_DEPTH; gi++) begin : g_slot
        assign busy_v[gi]           = slots[gi].busy;
        assign alloc_v[gi]          = disp_valid && is_load && !ld_full && free_idx == AGE_W'(gi);
        assign slots[gi].alloc      = alloc_v[gi];
        assign slots[gi].alloc_op   = load_op;
        assign slots[gi].alloc_age  = busy_cnt[AGE_W-1:0];
        assign slots[gi].alloc_deps = st_view.pending;
    end

endmodule

// File: hw/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter int LD_DEPTH = 4,
    parameter int ST_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  mem_rs_pkg::cdb_t        cdb,
    input  mem_rs_pkg::rob_idx_t    rob_head_idx,
    input  logic                    push,
    input  mem_rs_pkg::mem_op_t     push_op,
    st_view_if.queue                view
);

    localparam int IDX_W = $clog2(ST_DEPTH);

    mem_rs_pkg::mem_op_t  q [ST_DEPTH];
    logic [ST_DEPTH-1:0]  valid;
    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic                 head_wrap;
    logic                 tail_wrap;
    mem_rs_pkg::mem_op_t  head_op;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head      <= '0;
            tail      <= '0;
            head_wrap <= 1'b0;
            tail_wrap <= 1'b0;
            valid     <= '0;
        end else begin
            if (view.pop) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
                if (head == IDX_W'(ST_DEPTH - 1)) begin
                    head_wrap <= ~head_wrap;
                end
            end
            if (push) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
                if (tail == IDX_W'(ST_DEPTH - 1)) begin
                    tail_wrap <= ~tail_wrap;
                end
            end
        end
    end

    // a pushed op also sees this cycle's broadcast
    always_ff @(posedge clk) begin
        for (int i = 0; i < ST_DEPTH; i++) begin
            if (push && tail == IDX_W'(i)) begin
                q[i] <= mem_rs_pkg::wake_op(push_op, cdb);
            end else begin
                q[i] <= mem_rs_pkg::wake_op(q[i], cdb);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ST_DEPTH; i++) begin
            // base register is enough to place the store
            view.addr_known[i] = valid[i] && q[i].ps1_ready;
            view.addr[i]       = q[i].ps1_v + q[i].imm;
        end
    end

    assign head_op = q[head];

    assign view.pending    = valid;
    assign view.head_idx   = head;
    assign view.head_op    = head_op;
    assign view.head_ready = valid[head] && head_op.ps1_ready && head_op.ps2_ready
                             && head_op.rob_idx == rob_head_idx;
    assign view.full       = (head == tail) && (head_wrap != tail_wrap);

endmodule

// File: hw/ld_slot.sv
`timescale 1ns/1ps

module ld_slot #(
    parameter int LD_DEPTH = 4,
    parameter int ST_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  mem_rs_pkg::cdb_t             cdb,
    input  logic                         st_issue,
    input  logic [$clog2(ST_DEPTH)-1:0]  st_issue_idx,
    input  logic                         ld_issue,
    input  logic [$clog2(LD_DEPTH)-1:0]  ld_issue_age,
    ld_slot_if.slot                      slot
);

    localparam int AGE_W = $clog2(LD_DEPTH);

    logic                 busy;
    mem_rs_pkg::mem_op_t  op;
    logic [AGE_W-1:0]     age;
    logic [ST_DEPTH-1:0]  deps;
    logic [ST_DEPTH-1:0]  st_clr;
    mem_rs_pkg::word_t    addr;

    // bit of the store leaving the queue this cycle
    assign st_clr = st_issue ? (ST_DEPTH'(1) << st_issue_idx) : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
        end else if (slot.alloc) begin
            busy <= 1'b1;
        end else if (slot.grant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (slot.alloc) begin
            op   <= mem_rs_pkg::wake_op(slot.alloc_op, cdb);
            // an issuing load is always older than the one being written
            age  <= slot.alloc_age - AGE_W'(ld_issue);
            deps <= slot.alloc_deps & ~st_clr;
        end else begin
            op   <= mem_rs_pkg::wake_op(op, cdb);
            if (ld_issue && ld_issue_age < age) begin
                age <= age - 1'b1;
            end
            deps <= deps & ~st_clr;
        end
    end

    assign addr = op.ps1_v + op.imm;

    always_comb begin
        case (op.funct3)
            mem_rs_pkg::F3_LB,
            mem_rs_pkg::F3_LBU: slot.rmask = 4'b0001 << addr[1:0];
            mem_rs_pkg::F3_LH,
            mem_rs_pkg::F3_LHU: slot.rmask = 4'b0011 << addr[1:0];
            mem_rs_pkg::F3_LW:  slot.rmask = 4'b1111;
            default:            slot.rmask = 4'b0000;
        endcase
    end

    assign slot.busy  = busy;
    assign slot.ready = busy && op.ps1_ready && op.ps2_ready;
    assign slot.age   = age;
    assign slot.op    = op;
    assign slot.addr  = addr;
    assign slot.deps  = deps;

endmodule

// File: hw/st_view_if.sv
`timescale 1ns/1ps

interface st_view_if #(
    parameter int ST_DEPTH = 4
) ();

    localparam int IDX_W = $clog2(ST_DEPTH);

    logic [ST_DEPTH-1:0]  pending;
    logic [ST_DEPTH-1:0]  addr_known;
    mem_rs_pkg::word_t    addr [ST_DEPTH];
    logic [IDX_W-1:0]     head_idx;
    logic                 head_ready;
    mem_rs_pkg::mem_op_t  head_op;
    logic                 full;

    // head leaves the queue at the next edge
    logic                 pop;

    modport queue (output pending, addr_known, addr, head_idx, head_ready, head_op, full,
                   input pop);

    modport reader (input pending, full);

    modport selector (input addr_known, addr, head_idx, head_ready, head_op,
                      output pop);

endinterface

// File: hw/ld_slot_if.sv
`timescale 1ns/1ps

interface ld_slot_if #(
    parameter int ST_DEPTH = 4,
    parameter int LD_DEPTH = 4
) ();

    localparam int AGE_W = $clog2(LD_DEPTH);

    // written by the dispatcher
    logic                 alloc;
    mem_rs_pkg::mem_op_t  alloc_op;
    logic [AGE_W-1:0]     alloc_age;
    logic [ST_DEPTH-1:0]  alloc_deps;

    // slot state
    logic                 busy;
    logic                 ready;
    logic [AGE_W-1:0]     age;
    mem_rs_pkg::mem_op_t  op;
    mem_rs_pkg::word_t    addr;
    mem_rs_pkg::byte_mask_t rmask;
    logic [ST_DEPTH-1:0]  deps;

    logic                 grant;

    modport dispatcher (output alloc, alloc_op, alloc_age, alloc_deps, input busy);

    modport slot (input alloc, alloc_op, alloc_age, alloc_deps, grant,
                  output busy, ready, age, op, addr, rmask, deps);

    modport selector (input busy, ready, age, op, addr, rmask, deps, output grant);

endinterface

// File: hw/mem_rs_pkg.sv
package mem_rs_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  preg_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // result broadcast used to wake waiting operands
    typedef struct packed {
        logic  valid;
        preg_t tag;
        word_t value;
    } cdb_t;

    typedef struct packed {
        funct3_t  funct3;
        rob_idx_t rob_idx;
        preg_t    pd;
        preg_t    ps1;
        logic     ps1_ready;
        word_t    ps1_v;
        preg_t    ps2;
        logic     ps2_ready;
        word_t    ps2_v;
        word_t    imm;
    } mem_op_t;

    // apply one broadcast to both source operands of an entry
    function automatic mem_op_t wake_op(mem_op_t op, cdb_t cdb);
        mem_op_t res;
        res = op;
        if (cdb.valid && !op.ps1_ready && op.ps1 == cdb.tag) begin
            res.ps1_ready = 1'b1;
            res.ps1_v     = cdb.value;
        end
        if (cdb.valid && !op.ps2_ready && op.ps2 == cdb.tag) begin
            res.ps2_ready = 1'b1;
            res.ps2_v     = cdb.value;
        end
        return res;
    endfunction

endpackage
